//--- hdl/cnn_weight_defs.svh
`ifndef CNN_WEIGHT_DEFS_SVH
`define CNN_WEIGHT_DEFS_SVH

// float16 weights
`define DATA_WIDTH 16

// largest kernel edge, one slice holds KERNEL_SIZE_MAX squared elements
`define KERNEL_SIZE_MAX 3

`define PARA_Y 4 // weights returned per read

`define WEIGHT_WRITE_ADDR_WIDTH 6   // slice number, 64 slices
`define WEIGHT_READ_ADDR_WIDTH  10  // flat element index
`define FM_SIZE_WIDTH           5   // feature map edge

// total number of stored elements
`define WEIGHT_DEPTH ((1 << `WEIGHT_WRITE_ADDR_WIDTH) * `KERNEL_SIZE_MAX * `KERNEL_SIZE_MAX)

`endif

//--- hdl/cnn_types_pkg.sv
`include "cnn_weight_defs.svh"

package cnn_types_pkg;

    // one half precision weight
    typedef logic [`DATA_WIDTH-1:0] weight_t;

    // slice number on the write side
    typedef logic [`WEIGHT_WRITE_ADDR_WIDTH-1:0] slice_addr_t;

    // element index on the read side
    typedef logic [`WEIGHT_READ_ADDR_WIDTH-1:0] elem_addr_t;

    typedef logic [`FM_SIZE_WIDTH-1:0] fm_size_t; // feature map edge length

    // one flag per output lane
    typedef logic [`PARA_Y-1:0] lane_mask_t;

endpackage

//--- hdl/weight_bus_pkg.sv
`include "cnn_weight_defs.svh"

package weight_bus_pkg;

    // slice write, element 0 sits in the low 16 bits
    typedef struct packed {
        logic                                                            en;
        cnn_types_pkg::slice_addr_t                                      addr;
        cnn_types_pkg::weight_t [`KERNEL_SIZE_MAX*`KERNEL_SIZE_MAX-1:0]  data;
    } weight_slice_s;

    // lane addresses for one read port
    typedef struct packed {
        logic                                         en;
        cnn_types_pkg::elem_addr_t [`PARA_Y-1:0]      addr;
        cnn_types_pkg::lane_mask_t                    mask; // lane in range
    } lane_req_s;

    // registered read result of one port
    typedef struct packed {
        cnn_types_pkg::weight_t [`PARA_Y-1:0]  data;
        cnn_types_pkg::lane_mask_t             mask;
        logic                                  valid;
    } lane_data_s;

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_CONV, // consecutive weights
        MODE_FC    // strided by fm_size squared
    } read_mode_e;

endpackage

//--- hdl/weight_slice_ram.sv
`timescale 1ns/1ps

`include "cnn_weight_defs.svh"

module weight_slice_ram (
    input  logic                          clk,
    input  logic                          reset,
    input  weight_bus_pkg::weight_slice_s wr,
    input  weight_bus_pkg::lane_req_s     req_a,
    input  weight_bus_pkg::lane_req_s     req_b,
    output weight_bus_pkg::lane_data_s    rd_a,
    output weight_bus_pkg::lane_data_s    rd_b
);

    localparam int SLICE_ELEMS = `KERNEL_SIZE_MAX * `KERNEL_SIZE_MAX;
    localparam int NUM_PORTS   = 2;

    cnn_types_pkg::weight_t     mem [`WEIGHT_DEPTH];
    cnn_types_pkg::elem_addr_t  wr_base; // first element of the slice

    weight_bus_pkg::lane_req_s              req     [NUM_PORTS];
    cnn_types_pkg::weight_t [`PARA_Y-1:0]   data_q  [NUM_PORTS];
    cnn_types_pkg::lane_mask_t              mask_q  [NUM_PORTS];
    logic                                   valid_q [NUM_PORTS];

    assign wr_base = cnn_types_pkg::elem_addr_t'(wr.addr)
                   * cnn_types_pkg::elem_addr_t'(SLICE_ELEMS);

    // whole slice lands in one cycle
    always_ff @(posedge clk) begin
        if (wr.en) begin
            for (int k = 0; k < SLICE_ELEMS; k++) begin
                mem[wr_base + k] <= wr.data[k];
            end
        end
    end

    assign req[0] = req_a; // conv port
    assign req[1] = req_b; // fc port

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q[p] <= 1'b0;
                mask_q[p]  <= '0;
            end else begin
                valid_q[p] <= req[p].en;
                mask_q[p]  <= req[p].en ? req[p].mask : '0;
            end
        end

        // read first, sees the old word when a write hits the same element
        always_ff @(posedge clk) begin
            for (int i = 0; i < `PARA_Y; i++) begin
                if (req[p].en && req[p].mask[i]) begin
                    data_q[p][i] <= mem[req[p].addr[i]];
                end
            end
        end

        for (genvar i = 0; i < `PARA_Y; i++) begin : g_lane
            // the fetch units must never flag a lane past the end of memory
            a_lane_in_range: assert property (
                @(posedge clk) disable iff (reset)
                (req[p].en && req[p].mask[i]) |-> (req[p].addr[i] < `WEIGHT_DEPTH)
            ) else $error("lane %0d of port %0d out of range: %h", i, p, req[p].addr[i]);
        end
    end

    assign rd_a = '{data: data_q[0], mask: mask_q[0], valid: valid_q[0]};
    assign rd_b = '{data: data_q[1], mask: mask_q[1], valid: valid_q[1]};

endmodule

//--- hdl/conv_weight_fetch.sv
`timescale 1ns/1ps

`include "cnn_weight_defs.svh"

module conv_weight_fetch (
    input  logic                      ena_r,
    input  cnn_types_pkg::elem_addr_t addr_read,
    output weight_bus_pkg::lane_req_s req
);

    // one extra bit so a lane past the top is not lost to wraparound
    localparam int SUM_W = `WEIGHT_READ_ADDR_WIDTH + 1;

    logic [SUM_W-1:0] lane_sum [`PARA_Y];

    always_comb begin
        req.en = ena_r;
        for (int i = 0; i < `PARA_Y; i++) begin
            lane_sum[i] = SUM_W'(addr_read) + SUM_W'(i); // lane i reads addr_read + i
            req.addr[i] = lane_sum[i][`WEIGHT_READ_ADDR_WIDTH-1:0];
            // lanes beyond the last element come back as zero
            req.mask[i] = ena_r && (lane_sum[i] < SUM_W'(`WEIGHT_DEPTH));
        end
    end

endmodule

//--- hdl/fc_weight_fetch.sv
`timescale 1ns/1ps

`include "cnn_weight_defs.svh"

module fc_weight_fetch (
    input  logic                      clk,
    input  logic                      ena_fc_r,
    input  cnn_types_pkg::fm_size_t   fm_size,
    input  cnn_types_pkg::elem_addr_t addr_read,
    output weight_bus_pkg::lane_req_s req
);

    localparam int STRIDE_W = 2 * `FM_SIZE_WIDTH; // holds fm_size squared
    localparam int BASE_W   = (`WEIGHT_READ_ADDR_WIDTH > STRIDE_W) ?
                              `WEIGHT_READ_ADDR_WIDTH : STRIDE_W;
    localparam int SUM_W    = BASE_W + $clog2(`PARA_Y) + 1; // no overflow on the last lane

    logic [STRIDE_W-1:0] stride;
    logic [SUM_W-1:0]    offset;   // i * stride, built up lane by lane
    logic [SUM_W-1:0]    lane_sum;

    // one weight per output neuron, neurons are fm_size^2 apart
    assign stride = STRIDE_W'(fm_size) * STRIDE_W'(fm_size);

    always_comb begin
        offset = '0;
        req.en = ena_fc_r;
        for (int i = 0; i < `PARA_Y; i++) begin
            lane_sum    = SUM_W'(addr_read) + offset;
            req.addr[i] = lane_sum[`WEIGHT_READ_ADDR_WIDTH-1:0];
            req.mask[i] = ena_fc_r && (lane_sum < SUM_W'(`WEIGHT_DEPTH));
            offset      = offset + SUM_W'(stride);
        end
    end

    // a zero fm_size would point every lane at the same weight
    a_fm_size_nonzero: assert property (
        @(posedge clk) ena_fc_r |-> (fm_size != '0)
    ) else $error("fc read with fm_size of zero");

endmodule

//--- hdl/weight_read_combine.sv
`timescale 1ns/1ps

`include "cnn_weight_defs.svh"

module weight_read_combine (
    input  logic                              clk,
    input  logic                              reset,
    input  weight_bus_pkg::read_mode_e        mode,
    input  weight_bus_pkg::lane_data_s        rd_a,
    input  weight_bus_pkg::lane_data_s        rd_b,
    output logic [`PARA_Y*`DATA_WIDTH-1:0]    dout,
    output logic                              dout_valid
);

    weight_bus_pkg::read_mode_e            mode_q; // mode of the word now leaving the ram
    weight_bus_pkg::lane_data_s            sel;
    cnn_types_pkg::weight_t [`PARA_Y-1:0]  lanes;  // lane 0 in the low bits

    always_ff @(posedge clk) begin
        if (reset) begin
            mode_q <= weight_bus_pkg::MODE_IDLE;
        end else begin
            mode_q <= mode;
        end
    end

    always_comb begin
        case (mode_q)
            weight_bus_pkg::MODE_CONV: sel = rd_a;
            weight_bus_pkg::MODE_FC:   sel = rd_b;
            default:                   sel = '0;
        endcase
    end

    always_comb begin
        for (int i = 0; i < `PARA_Y; i++) begin
            lanes[i] = sel.mask[i] ? sel.data[i] : '0; // out of range reads as zero
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dout       <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout       <= lanes;
            dout_valid <= sel.valid;
        end
    end

    // only one mode is fetched per cycle upstream
    a_one_port: assert property (
        @(posedge clk) disable iff (reset) !(rd_a.valid && rd_b.valid)
    ) else $error("both ram ports valid together");

    // every ram result shows up on dout one cycle later
    a_valid_follows: assert property (
        @(posedge clk) disable iff (reset) (rd_a.valid || rd_b.valid) |=> dout_valid
    ) else $error("dout_valid missing after a valid ram read");

endmodule

//--- hdl/weight_store_top.sv
`timescale 1ns/1ps

`include "cnn_weight_defs.svh"

module weight_store_top (
    input  logic                                                     clk,
    input  logic                                                     reset,
    input  logic                                                     ena_w,
    input  cnn_types_pkg::slice_addr_t                               addr_write,
    input  logic [`KERNEL_SIZE_MAX*`KERNEL_SIZE_MAX*`DATA_WIDTH-1:0] din,
    input  logic                                                     ena_r,
    input  logic                                                     ena_fc_r,
    input  cnn_types_pkg::fm_size_t                                  fm_size,
    input  cnn_types_pkg::elem_addr_t                                addr_read,
    output logic [`PARA_Y*`DATA_WIDTH-1:0]                           dout,
    output logic                                                     dout_valid
);

    weight_bus_pkg::weight_slice_s wr_slice;
    weight_bus_pkg::lane_req_s     conv_req;
    weight_bus_pkg::lane_req_s     fc_req;
    weight_bus_pkg::lane_data_s    rd_a;
    weight_bus_pkg::lane_data_s    rd_b;
    weight_bus_pkg::read_mode_e    mode;
    logic                          fc_en;

    assign wr_slice.en   = ena_w;
    assign wr_slice.addr = addr_write;
    assign wr_slice.data = din;

    // conv has priority when both enables are up
    assign mode = ena_r    ? weight_bus_pkg::MODE_CONV :
                  ena_fc_r ? weight_bus_pkg::MODE_FC   : weight_bus_pkg::MODE_IDLE;

    assign fc_en = (mode == weight_bus_pkg::MODE_FC);

    conv_weight_fetch u_conv (
        .ena_r     (ena_r),
        .addr_read (addr_read),
        .req       (conv_req)
    );

    fc_weight_fetch u_fc (
        .clk       (clk),
        .ena_fc_r  (fc_en),
        .fm_size   (fm_size),
        .addr_read (addr_read),
        .req       (fc_req)
    );

    weight_slice_ram u_ram (
        .clk   (clk),
        .reset (reset),
        .wr    (wr_slice),
        .req_a (conv_req),
        .req_b (fc_req),
        .rd_a  (rd_a),
        .rd_b  (rd_b)
    );

    weight_read_combine u_combine (
        .clk        (clk),
        .reset      (reset),
        .mode       (mode),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

    a_single_mode: assert property (
        @(posedge clk) disable iff (reset) !(ena_r && ena_fc_r)
    ) else $error("ena_r and ena_fc_r both high, fc read dropped");

endmodule

//--- tests/weight_store_tb.sv
`timescale 1ns/1ps

`include "cnn_weight_defs.svh"

module weight_store_tb;

    localparam int SLICE_ELEMS = `KERNEL_SIZE_MAX * `KERNEL_SIZE_MAX;
    localparam int NUM_SLICES  = 1 << `WEIGHT_WRITE_ADDR_WIDTH;
    localparam int DEPTH       = NUM_SLICES * SLICE_ELEMS;
    localparam int WORD_W      = `PARA_Y * `DATA_WIDTH;
    localparam int SLICE_W     = SLICE_ELEMS * `DATA_WIDTH;
    localparam int MAX_CYCLES  = 2000; // stimulus runs well under half of this

    // one expected output cycle
    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] word;
    } exp_entry_s;

    logic                       clk;
    logic                       reset;
    logic                       ena_w;
    cnn_types_pkg::slice_addr_t addr_write;
    logic [SLICE_W-1:0]         din;
    logic                       ena_r;
    logic                       ena_fc_r;
    cnn_types_pkg::fm_size_t    fm_size;
    cnn_types_pkg::elem_addr_t  addr_read;
    logic [WORD_W-1:0]          dout;
    logic                       dout_valid;

    logic [`DATA_WIDTH-1:0] model_mem [DEPTH]; // mirror of the weight memory
    exp_entry_s             pending [$];        // requests still in the pipeline
    int                     cycle_count = 0;
    int                     fail_count  = 0;

    weight_store_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .ena_w      (ena_w),
        .addr_write (addr_write),
        .din        (din),
        .ena_r      (ena_r),
        .ena_fc_r   (ena_fc_r),
        .fm_size    (fm_size),
        .addr_read  (addr_read),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    task automatic stop_on_failure();
        fail_count++;
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    // lanes past the last element read as zero
    function automatic logic [WORD_W-1:0] expected_word(input logic is_fc, input int base,
                                                        input int fm);
        logic [WORD_W-1:0] word;
        int                elem;
        word = '0;
        for (int i = 0; i < `PARA_Y; i++) begin
            elem = is_fc ? base + i * fm * fm : base + i;
            if (elem < DEPTH) begin
                word[i*`DATA_WIDTH +: `DATA_WIDTH] = model_mem[elem];
            end
        end
        return word;
    endfunction

    // inputs are stable at the falling edge, result due two falling edges later
    always @(negedge clk) begin
        exp_entry_s cur;
        exp_entry_s due;
        cur.valid = !reset && (ena_r || ena_fc_r);
        cur.word  = '0;
        if (cur.valid) begin
            cur.word = expected_word(!ena_r, int'(addr_read), int'(fm_size)); // conv wins
        end
        if (ena_w) begin // read first, so update after the lookup
            for (int k = 0; k < SLICE_ELEMS; k++) begin
                model_mem[int'(addr_write) * SLICE_ELEMS + k] = din[k*`DATA_WIDTH +: `DATA_WIDTH];
            end
        end
        if (pending.size() == 2) begin
            due = pending.pop_front();
            if (!reset) begin
                check_valid: assert (dout_valid === due.valid) else begin
                    $display("FAIL dout_valid: got %h expected %h", dout_valid, due.valid);
                    stop_on_failure();
                end
                if (due.valid) begin
                    check_dout: assert (dout === due.word) else begin
                        $display("FAIL dout: got %h expected %h", dout, due.word);
                        stop_on_failure();
                    end
                end
            end
        end
        pending.push_back(cur);
    end

    task automatic drive_cycle(input logic w, input int slice, input logic [SLICE_W-1:0] data,
                               input logic conv, input logic fc, input int fm, input int raddr);
        @(posedge clk);
        ena_w      <= w;
        addr_write <= cnn_types_pkg::slice_addr_t'(slice);
        din        <= data;
        ena_r      <= conv;
        ena_fc_r   <= fc;
        fm_size    <= cnn_types_pkg::fm_size_t'(fm);
        addr_read  <= cnn_types_pkg::elem_addr_t'(raddr);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 0, '0, 1'b0, 1'b0, 1, 0);
    endtask

    task automatic write_slice(input int slice, input logic [SLICE_W-1:0] data);
        drive_cycle(1'b1, slice, data, 1'b0, 1'b0, 1, 0);
    endtask

    task automatic conv_read(input int raddr);
        drive_cycle(1'b0, 0, '0, 1'b1, 1'b0, 1, raddr);
    endtask

    task automatic fc_read(input int raddr, input int fm);
        drive_cycle(1'b0, 0, '0, 1'b0, 1'b1, fm, raddr);
    endtask

    function automatic logic [SLICE_W-1:0] random_slice();
        logic [SLICE_W-1:0] data;
        for (int k = 0; k < SLICE_ELEMS; k++) begin
            data[k*`DATA_WIDTH +: `DATA_WIDTH] = `DATA_WIDTH'($urandom);
        end
        return data;
    endfunction

    initial begin
        int unused_seed;
        int slice;
        unused_seed = $urandom(32'h44e948d8);
        reset      = 1'b1;
        ena_w      = 1'b0;
        addr_write = '0;
        din        = '0;
        ena_r      = 1'b0;
        ena_fc_r   = 1'b0;
        fm_size    = 5'd1;
        addr_read  = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        repeat (4) idle_cycle(); // nothing valid before the first read
        for (int s = 0; s < NUM_SLICES; s++) begin
            write_slice(s, random_slice());
        end
        repeat (3) idle_cycle();

        for (int a = 0; a < DEPTH; a += `PARA_Y) begin
            conv_read(a);
        end
        for (int s = 1; s < NUM_SLICES; s++) begin
            conv_read(s * SLICE_ELEMS - 2); // straddles a slice boundary
        end

        // top of memory, partial and fully out of range
        for (int a = DEPTH - `PARA_Y; a < DEPTH + 2; a++) begin
            conv_read(a);
        end
        conv_read((1 << `WEIGHT_READ_ADDR_WIDTH) - 1);

        repeat (80) fc_read($urandom_range(DEPTH - 1, 0), $urandom_range(7, 1));

        // modes alternate every cycle
        repeat (20) begin
            conv_read($urandom_range(DEPTH - 1, 0));
            fc_read($urandom_range(DEPTH - 1, 0), $urandom_range(7, 1));
        end

        // write and read the same slice in one cycle, then read again
        repeat (6) begin
            slice = $urandom_range(NUM_SLICES - 1, 0);
            drive_cycle(1'b1, slice, random_slice(), 1'b1, 1'b0, 1, slice * SLICE_ELEMS);
            conv_read(slice * SLICE_ELEMS);
            slice = $urandom_range(NUM_SLICES - 1, 0);
            drive_cycle(1'b1, slice, random_slice(), 1'b0, 1'b1, 1, slice * SLICE_ELEMS + 1);
            fc_read(slice * SLICE_ELEMS + 1, 1);
        end

        repeat (5) idle_cycle(); // drain the pipeline
        @(negedge clk);

        if (fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- all.f
+incdir+hdl
hdl/cnn_types_pkg.sv
hdl/weight_bus_pkg.sv
hdl/weight_slice_ram.sv
hdl/conv_weight_fetch.sv
hdl/fc_weight_fetch.sv
hdl/weight_read_combine.sv
hdl/weight_store_top.sv
tests/weight_store_tb.sv

//--- Bender.yml
package:
  name: cnn_weight_store

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cnn_types_pkg.sv
      - hdl/weight_bus_pkg.sv
      - hdl/weight_slice_ram.sv
      - hdl/conv_weight_fetch.sv
      - hdl/fc_weight_fetch.sv
      - hdl/weight_read_combine.sv
      - hdl/weight_store_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - tests/weight_store_tb.sv
